// ==== eth_mac_fifo.f ====
+incdir+.
eth_mac_fifo_pkg.sv
byte_stream_if.sv
packet_fifo.sv
eth_tx_framer.sv
eth_rx_parser.sv
eth_mac_fifo.sv
tb_eth_mac_fifo.sv

// ==== tb_eth_mac_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

module tb_eth_mac_fifo;

    typedef logic [7:0] byte_q_t[$];

    localparam int TIMEOUT = 5000;  // Cycles allowed for any single wait

    logic                   clk_125;
    logic                   i_reset_n;
    logic [`DATA_WIDTH-1:0] tx_tdata;
    logic                   tx_tvalid;
    logic                   tx_tlast;
    logic                   tx_tuser;
    wire                    tx_tready;
    wire  [`DATA_WIDTH-1:0] rx_tdata;
    wire                    rx_tvalid;
    wire                    rx_tlast;
    logic                   rx_tready;
    wire  [`DATA_WIDTH-1:0] gmii_txd;
    wire                    gmii_tx_en;
    wire  [`DATA_WIDTH-1:0] gmii_rxd;
    wire                    gmii_rx_dv;

    logic                   loopback;   // Route GMII transmit back into receive
    logic [`DATA_WIDTH-1:0] inj_rxd;    // Injected receive byte
    logic                   inj_rx_dv;
    int                     rx_mode;    // 0 ready high, 1 ready low, 2 irregular

    logic [31:0] lfsr;                  // Stimulus random state
    logic [31:0] rdy_lfsr;              // Separate state for the ready pattern
    byte_q_t     pay;                   // Payload under construction

    byte_q_t     exp_tx_bytes;          // Expected GMII bytes of all frames in a row
    int          exp_tx_len[$];         // Expected tx_en high cycles per frame
    byte_q_t     exp_rx_data;           // Expected host receive bytes
    logic        exp_rx_last[$];

    int          err_cnt;
    int          err_at_start;
    int          pass_cnt;
    int          fail_cnt;
    int          tx_cnt;                // Bytes seen in current GMII frame
    int          idle_cnt;              // Idle cycles since last frame
    bit          saw_tx_frame;
    logic [7:0]  exp_byte;
    logic        exp_last;
    int          exp_len;

    assign gmii_rxd   = loopback ? gmii_txd   : inj_rxd;
    assign gmii_rx_dv = loopback ? gmii_tx_en : inj_rx_dv;

    eth_mac_fifo UUT (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .tx_tdata   (tx_tdata),
        .tx_tvalid  (tx_tvalid),
        .tx_tlast   (tx_tlast),
        .tx_tuser   (tx_tuser),
        .tx_tready  (tx_tready),
        .rx_tdata   (rx_tdata),
        .rx_tvalid  (rx_tvalid),
        .rx_tlast   (rx_tlast),
        .rx_tready  (rx_tready),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv)
    );

    initial begin
        clk_125 = 1'b0;
        forever #2 clk_125 = ~clk_125;  // 4 ns period
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // One step per bit taken
        end
    endtask

    // MSB-first 802.3 CRC with data bits fed LSB first and the result reflected
    function automatic logic [31:0] fcs_ref(input byte_q_t d);
        logic [31:0] r;
        logic [31:0] refl;
        logic        fb;
        r = 32'hFFFFFFFF;
        foreach (d[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[31] ^ d[k][b];
                r  = {r[30:0], 1'b0};
                if (fb) begin
                    r = r ^ 32'h04C11DB7;
                end
            end
        end
        for (int b = 0; b < 32; b++) begin
            refl[b] = r[31-b];
        end
        return ~refl;
    endfunction

    task automatic make_payload(input int len);
        logic [31:0] v;
        pay.delete();
        for (int i = 0; i < len; i++) begin
            rand_bits(8, v);
            pay.push_back(v[7:0]);
        end
    endtask

    task automatic push_rx(input byte_q_t b);
        foreach (b[k]) begin
            exp_rx_data.push_back(b[k]);
            exp_rx_last.push_back(k == b.size() - 1);  // tlast on final byte
        end
    endtask

    // Expected GMII frame for the current payload
    task automatic expect_tx(input bit to_rx);
        byte_q_t     body;
        logic [31:0] fcs;
        body = pay;
        while (body.size() < `MIN_PAYLOAD) begin
            body.push_back(8'h00);  // Zero pad to minimum
        end
        fcs = fcs_ref(body);
        repeat (7) exp_tx_bytes.push_back(8'h55);
        exp_tx_bytes.push_back(8'hD5);
        foreach (body[k]) begin
            exp_tx_bytes.push_back(body[k]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_tx_bytes.push_back(fcs[8*k +: 8]);  // Low byte first
        end
        exp_tx_len.push_back(8 + body.size() + 4);
        if (to_rx) begin
            push_rx(body);
        end
    endtask

    task automatic send_host(input bit discard);
        int cyc;
        for (int i = 0; i < pay.size(); i++) begin
            @(negedge clk_125);
            tx_tdata  = pay[i];
            tx_tvalid = 1'b1;
            tx_tlast  = (i == pay.size() - 1);
            tx_tuser  = discard && (i == pay.size() - 1);
            cyc = 0;
            @(posedge clk_125);
            while (!tx_tready && cyc < TIMEOUT) begin
                @(posedge clk_125);
                cyc++;
            end
            assert (cyc < TIMEOUT) else begin
                $display("ERROR: tx_tready stayed low, host byte %0d not accepted", i);
                err_cnt++;
            end
        end
        @(negedge clk_125);
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        tx_tuser  = 1'b0;
    endtask

    // Drives one frame on the receive GMII port and flips a bit unless corrupt_at is negative
    task automatic inject(input int corrupt_at);
        byte_q_t     wire_q;
        logic [31:0] fcs;
        fcs = fcs_ref(pay);
        repeat (7) wire_q.push_back(8'h55);
        wire_q.push_back(8'hD5);
        foreach (pay[k]) begin
            wire_q.push_back(pay[k]);
        end
        for (int k = 0; k < 4; k++) begin
            wire_q.push_back(fcs[8*k +: 8]);
        end
        if (corrupt_at >= 0) begin
            wire_q[8 + corrupt_at] = wire_q[8 + corrupt_at] ^ 8'h10;  // Single bit flip
        end
        foreach (wire_q[k]) begin
            @(negedge clk_125);
            inj_rxd   = wire_q[k];
            inj_rx_dv = 1'b1;
        end
        @(negedge clk_125);
        inj_rxd   = '0;
        inj_rx_dv = 1'b0;
        repeat (`IFG_CYCLES) @(negedge clk_125);
    endtask

    task automatic set_ready_mode(input int m);
        @(posedge clk_125);
        rx_mode = m;  // Picked up by the ready driver on the next falling edge
    endtask

    task automatic route_loopback(input logic on);
        @(negedge clk_125);
        loopback = on;  // Mux switches on the falling edge like every other input
    endtask

    // Values the DUT holds while reset is applied
    task automatic check_reset_state();
        assert (tx_tready === 1'b1) else begin
            $display("MISMATCH tx_tready: got 0x%h expected 0x1", tx_tready);
            err_cnt++;
        end
        assert (gmii_tx_en === 1'b0) else begin
            $display("MISMATCH gmii_tx_en: got 0x%h expected 0x0", gmii_tx_en);
            err_cnt++;
        end
        assert (rx_tvalid === 1'b0) else begin
            $display("MISMATCH rx_tvalid: got 0x%h expected 0x0", rx_tvalid);
            err_cnt++;
        end
    endtask

    task automatic wait_done();
        int cyc;
        cyc = 0;
        while ((exp_tx_len.size() != 0 || exp_rx_data.size() != 0) && cyc < TIMEOUT) begin
            @(posedge clk_125);
            cyc++;
        end
        assert (cyc < TIMEOUT) else begin
            $display("ERROR: timeout with %0d GMII frames and %0d host bytes still missing",
                     exp_tx_len.size(), exp_rx_data.size());
            err_cnt++;
            exp_tx_bytes.delete();
            exp_tx_len.delete();
            exp_rx_data.delete();
            exp_rx_last.delete();
        end
    endtask

    task automatic finish_test(input string name);
        wait_done();
        if (err_cnt == err_at_start) begin
            pass_cnt++;
            $display("Test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("Test %s: fail, %0d errors", name, err_cnt - err_at_start);
        end
        err_at_start = err_cnt;
    endtask

    // Host receive ready pattern
    always @(negedge clk_125) begin
        if (rx_mode == 2) begin
            rdy_lfsr  = lfsr_next(rdy_lfsr);
            rdy_lfsr  = lfsr_next(rdy_lfsr);
            rx_tready = !(rdy_lfsr[0] && rdy_lfsr[1]);  // Low about a quarter of cycles
        end else begin
            rx_tready = (rx_mode == 0);
        end
    end

    // GMII transmit checker
    always @(posedge clk_125) begin
        if (i_reset_n) begin
            if (gmii_tx_en) begin
                if (tx_cnt == 0) begin
                    assert (exp_tx_len.size() != 0) else begin
                        $display("ERROR: frame started on GMII with none expected");
                        err_cnt++;
                    end
                    if (saw_tx_frame) begin
                        assert (idle_cnt >= `IFG_CYCLES) else begin
                            $display("MISMATCH ifg_idle_cycles: got 0x%h expected >= 0x%h",
                                     idle_cnt, `IFG_CYCLES);
                            err_cnt++;
                        end
                    end
                end
                if (exp_tx_bytes.size() != 0) begin
                    exp_byte = exp_tx_bytes.pop_front();
                    assert (gmii_txd == exp_byte) else begin
                        $display("MISMATCH gmii_txd: got 0x%h expected 0x%h at byte %0d",
                                 gmii_txd, exp_byte, tx_cnt);
                        err_cnt++;
                    end
                end
                tx_cnt++;
                idle_cnt = 0;
            end else begin
                if (tx_cnt != 0 && exp_tx_len.size() != 0) begin
                    exp_len = exp_tx_len.pop_front();
                    assert (tx_cnt == exp_len) else begin
                        $display("MISMATCH gmii_tx_en length: got 0x%h expected 0x%h",
                                 tx_cnt, exp_len);
                        err_cnt++;
                    end
                end
                if (tx_cnt != 0) begin
                    saw_tx_frame = 1'b1;
                end
                tx_cnt = 0;
                idle_cnt++;
            end
        end
    end

    // Host receive checker on each edge where valid and ready meet
    always @(posedge clk_125) begin
        if (i_reset_n && rx_tvalid && rx_tready) begin
            assert (exp_rx_data.size() != 0) else begin
                $display("ERROR: byte 0x%h reached the host receive port unexpectedly",
                         rx_tdata);
                err_cnt++;
            end
            if (exp_rx_data.size() != 0) begin
                exp_byte = exp_rx_data.pop_front();
                exp_last = exp_rx_last.pop_front();
                assert (rx_tdata == exp_byte) else begin
                    $display("MISMATCH rx_tdata: got 0x%h expected 0x%h", rx_tdata, exp_byte);
                    err_cnt++;
                end
                assert (rx_tlast == exp_last) else begin
                    $display("MISMATCH rx_tlast: got 0x%h expected 0x%h", rx_tlast, exp_last);
                    err_cnt++;
                end
            end
        end
    end

    initial begin
        logic [31:0] v;
        int          len;
        i_reset_n    = 1'b0;
        tx_tdata     = '0;
        tx_tvalid    = 1'b0;
        tx_tlast     = 1'b0;
        tx_tuser     = 1'b0;
        rx_tready    = 1'b1;
        rx_mode      = 0;
        loopback     = 1'b0;
        inj_rxd      = '0;
        inj_rx_dv    = 1'b0;
        lfsr         = 32'h76672eaa;
        rdy_lfsr     = 32'h76672eaa;
        err_cnt      = 0;
        err_at_start = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        tx_cnt       = 0;
        idle_cnt     = 0;
        saw_tx_frame = 1'b0;
        repeat (8) @(posedge clk_125);
        @(negedge clk_125);
        check_reset_state();
        i_reset_n = 1'b1;
        finish_test("0 reset state");

        for (int f = 0; f < 8; f++) begin  // Transmit format only
            rand_bits(7, v);
            make_payload((v % 100) + 1);
            expect_tx(1'b0);
            send_host(1'b0);
        end
        finish_test("1 transmit format");

        route_loopback(1'b1);
        for (int f = 0; f < 6; f++) begin
            rand_bits(7, v);
            make_payload((v % 100) + 1);
            expect_tx(1'b1);
            send_host(1'b0);
        end
        finish_test("2 loopback");

        rand_bits(7, v);
        make_payload((v % 100) + 1);
        send_host(1'b1);                   // Dropped in the transmit buffer
        rand_bits(7, v);
        make_payload((v % 100) + 1);
        expect_tx(1'b1);
        send_host(1'b0);
        finish_test("3 host discard");

        route_loopback(1'b0);
        for (int f = 0; f < 5; f++) begin  // Good, bad CRC, good, runt, good
            rand_bits(6, v);
            len = (f == 3) ? 40 : ((f == 1) ? 70 : 60 + (v % 41));
            make_payload(len);
            if (f % 2 == 0) begin
                push_rx(pay);
            end
            inject((f == 1) ? 10 : -1);
        end
        finish_test("4 CRC and runt rejection");

        set_ready_mode(1);
        for (int f = 0; f < 4; f++) begin  // Only the first two fit
            make_payload(100);
            if (f < 2) begin
                push_rx(pay);
            end
            inject(-1);
        end
        set_ready_mode(0);
        finish_test("5 receive overflow");

        route_loopback(1'b1);
        set_ready_mode(2);
        for (int f = 0; f < 4; f++) begin
            rand_bits(7, v);
            make_payload((v % 100) + 1);
            expect_tx(1'b1);
            send_host(1'b0);
        end
        finish_test("6 gap and back-pressure");
        set_ready_mode(0);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_mac_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

module eth_mac_fifo (
    input  wire                   clk_125,
    input  wire                   i_reset_n,
    input  wire [`DATA_WIDTH-1:0] tx_tdata,     // Host frame bytes
    input  wire                   tx_tvalid,
    input  wire                   tx_tlast,
    input  wire                   tx_tuser,     // With tlast, discard the frame
    output wire                   tx_tready,
    output wire [`DATA_WIDTH-1:0] rx_tdata,     // Good frames only
    output wire                   rx_tvalid,
    output wire                   rx_tlast,
    input  wire                   rx_tready,
    output wire [`DATA_WIDTH-1:0] gmii_txd,
    output wire                   gmii_tx_en,
    input  wire [`DATA_WIDTH-1:0] gmii_rxd,
    input  wire                   gmii_rx_dv
);

    byte_stream_if tx_in_s ();   // Host to transmit buffer
    byte_stream_if tx_out_s ();  // Whole frames to the framer
    byte_stream_if rx_in_s ();   // Parser to receive buffer
    byte_stream_if rx_out_s ();  // Receive buffer to host

    assign tx_in_s.data  = tx_tdata;
    assign tx_in_s.valid = tx_tvalid;
    assign tx_in_s.last  = tx_tlast;
    assign tx_in_s.err   = tx_tuser;
    assign tx_tready     = tx_in_s.ready;

    assign rx_tdata       = rx_out_s.data;
    assign rx_tvalid      = rx_out_s.valid;
    assign rx_tlast       = rx_out_s.last;
    assign rx_out_s.ready = rx_tready;

    packet_fifo #(
        .DEPTH        (`TX_FIFO_DEPTH),
        .DROP_ON_FULL (1'b0)            // Host stalls on ready
    ) tx_buffer (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .wr_s      (tx_in_s.sink),
        .rd_s      (tx_out_s.source)
    );

    eth_tx_framer tx_framer (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .in_s       (tx_out_s.sink),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    eth_rx_parser rx_parser (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .out_s      (rx_in_s.source)
    );

    packet_fifo #(
        .DEPTH        (`RX_FIFO_DEPTH),
        .DROP_ON_FULL (1'b1)            // Line side cannot be held off
    ) rx_buffer (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .wr_s      (rx_in_s.sink),
        .rd_s      (rx_out_s.source)
    );

endmodule

`default_nettype wire

// ==== eth_rx_parser.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

module eth_rx_parser (
    input  wire                   clk_125,
    input  wire                   i_reset_n,
    input  wire [`DATA_WIDTH-1:0] gmii_rxd,
    input  wire                   gmii_rx_dv,
    byte_stream_if.source         out_s
);

    import eth_mac_fifo_pkg::*;

    // FCS bytes plus the held byte whose last flag is still open
    localparam int LINE_LEN  = FCS_BYTES + 1;
    localparam int MIN_FRAME = `MIN_PAYLOAD + FCS_BYTES;  // Runt limit, FCS included
    localparam int FILL_W    = $clog2(LINE_LEN + 1);
    localparam int LEN_W     = $clog2(MIN_FRAME + 1);

    localparam logic [1:0] ST_HUNT = 2'd0;  // Preamble, waiting for SFD
    localparam logic [1:0] ST_DATA = 2'd1;  // Frame body
    localparam logic [1:0] ST_SKIP = 2'd2;  // Junk before SFD, wait for dv low

    logic [1:0]             state;
    logic [`DATA_WIDTH-1:0] dly [LINE_LEN];  // dly[0] newest
    logic [FILL_W-1:0]      fill;            // Bytes held in the line
    logic [LEN_W-1:0]       len;             // Frame bytes, saturates at MIN_FRAME
    logic [31:0]            crc;             // Runs over data and FCS
    logic                   line_full;

    assign line_full = (fill == FILL_W'(LINE_LEN));

    // Frame tracking and output strobes, ready is not looked at
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state       <= ST_HUNT;
            fill        <= '0;
            len         <= '0;
            out_s.valid <= 1'b0;
            out_s.last  <= 1'b0;
            out_s.err   <= 1'b0;
        end else begin
            out_s.valid <= 1'b0;
            case (state)
                ST_HUNT: begin
                    fill <= '0;
                    len  <= '0;
                    if (gmii_rx_dv) begin
                        if (gmii_rxd == SFD_BYTE) begin
                            state <= ST_DATA;
                        end else if (gmii_rxd != PREAMBLE_BYTE) begin
                            state <= ST_SKIP;  // Not a preamble, ignore this burst
                        end
                    end
                end
                ST_DATA: begin
                    if (gmii_rx_dv) begin
                        if (!line_full) begin
                            fill <= fill + 1'b1;
                        end
                        if (len != LEN_W'(MIN_FRAME)) begin
                            len <= len + 1'b1;
                        end
                        if (line_full) begin
                            out_s.valid <= 1'b1;  // Oldest byte has more than FCS behind it
                            out_s.last  <= 1'b0;
                            out_s.err   <= 1'b0;
                        end
                    end else begin
                        state <= ST_HUNT;
                        if (line_full) begin
                            out_s.valid <= 1'b1;  // Held byte is the final payload byte
                            out_s.last  <= 1'b1;
                            out_s.err   <= (crc != CRC_RESIDUE) || (len != LEN_W'(MIN_FRAME));
                        end
                    end
                end
                ST_SKIP: begin
                    if (!gmii_rx_dv) begin
                        state <= ST_HUNT;
                    end
                end
                default: begin
                    state <= ST_HUNT;
                end
            endcase
        end
    end

    // Delay line, CRC and output byte
    always_ff @(posedge clk_125) begin
        if (state != ST_DATA) begin
            crc <= CRC_INIT;
        end else if (gmii_rx_dv) begin
            crc    <= crc32_step(crc, gmii_rxd);
            dly[0] <= gmii_rxd;
            for (int i = 1; i < LINE_LEN; i++) begin
                dly[i] <= dly[i-1];
            end
        end
        if ((state == ST_DATA) && line_full) begin
            out_s.data <= dly[LINE_LEN-1];  // Oldest byte, read before the shift
        end
    end

endmodule

`default_nettype wire

// ==== eth_tx_framer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

module eth_tx_framer (
    input  wire                    clk_125,
    input  wire                    i_reset_n,
    byte_stream_if.sink            in_s,
    output logic [`DATA_WIDTH-1:0] gmii_txd,
    output logic                   gmii_tx_en
);

    import eth_mac_fifo_pkg::*;

    localparam int CNT_W = $clog2(`TX_FIFO_DEPTH) + 1;  // Counts payload bytes too

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_PRE     = 3'd1;
    localparam logic [2:0] ST_SFD     = 3'd2;
    localparam logic [2:0] ST_PAYLOAD = 3'd3;
    localparam logic [2:0] ST_PAD     = 3'd4;
    localparam logic [2:0] ST_FCS     = 3'd5;
    localparam logic [2:0] ST_GAP     = 3'd6;

    logic [2:0]       state;
    logic [CNT_W-1:0] cnt;  // Byte index in the current phase
    logic [31:0]      crc;  // Running CRC over payload and pad

    assign in_s.ready = (state == ST_PAYLOAD);  // Whole frame buffered, so one byte per cycle

    // Phase sequencing and tx_en
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_s.valid) begin
                        state      <= ST_PRE;
                        cnt        <= CNT_W'(1);  // First preamble byte goes out now
                        gmii_tx_en <= 1'b1;
                    end
                end
                ST_PRE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(PREAMBLE_LEN - 1)) begin
                        state <= ST_SFD;
                    end
                end
                ST_SFD: begin
                    state <= ST_PAYLOAD;
                    cnt   <= '0;
                end
                ST_PAYLOAD: begin
                    if (in_s.valid) begin
                        cnt <= cnt + 1'b1;
                        if (in_s.last) begin
                            if (cnt >= CNT_W'(`MIN_PAYLOAD - 1)) begin
                                state <= ST_FCS;  // Long enough, no pad
                                cnt   <= '0;
                            end else begin
                                state <= ST_PAD;
                            end
                        end
                    end
                end
                ST_PAD: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`MIN_PAYLOAD - 1)) begin
                        state <= ST_FCS;
                        cnt   <= '0;
                    end
                end
                ST_FCS: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(FCS_BYTES - 1)) begin
                        state <= ST_GAP;
                        cnt   <= '0;
                    end
                end
                ST_GAP: begin
                    gmii_tx_en <= 1'b0;
                    cnt        <= cnt + 1'b1;
                    if (cnt == CNT_W'(`IFG_CYCLES - 1)) begin
                        state <= ST_IDLE;
                        cnt   <= '0;
                    end
                end
                default: begin
                    state      <= ST_IDLE;
                    gmii_tx_en <= 1'b0;
                end
            endcase
        end
    end

    // Byte selection and CRC
    always_ff @(posedge clk_125) begin
        case (state)
            ST_IDLE: begin
                gmii_txd <= in_s.valid ? PREAMBLE_BYTE : '0;
            end
            ST_PRE: begin
                gmii_txd <= PREAMBLE_BYTE;
            end
            ST_SFD: begin
                gmii_txd <= SFD_BYTE;
                crc      <= CRC_INIT;  // Preset before the first payload byte
            end
            ST_PAYLOAD: begin
                if (in_s.valid) begin
                    gmii_txd <= in_s.data;
                    crc      <= crc32_step(crc, in_s.data);
                end
            end
            ST_PAD: begin
                gmii_txd <= '0;
                crc      <= crc32_step(crc, '0);  // Pad bytes are covered by the FCS
            end
            ST_FCS: begin
                gmii_txd <= ~crc[7:0];     // Complemented, low byte first
                crc      <= crc >> 8;
            end
            default: begin
                gmii_txd <= '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== packet_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

module packet_fifo #(
    parameter int DEPTH        = 256,   // Bytes, power of two
    parameter bit DROP_ON_FULL = 1'b0   // Writer cannot stall, so a full write loses the frame
) (
    input wire            clk_125,
    input wire            i_reset_n,
    byte_stream_if.sink   wr_s,
    byte_stream_if.source rd_s
);

    localparam int AW = $clog2(DEPTH);

    logic [`DATA_WIDTH:0] mem [DEPTH];  // {last, data}

    logic [AW:0] wr_ptr;       // Next write slot, wrap bit on top
    logic [AW:0] commit_ptr;   // End of last good frame, read side limit
    logic [AW:0] rd_ptr;       // Next slot to fetch into the output register
    logic        commit_pend;  // Good last written, commit on next edge
    logic        ovf;          // Current frame lost a byte

    logic full;
    logic wr_fire;
    logic lost;
    logic end_frame;
    logic bad;
    logic avail;
    logic load;

    // Full when pointers match apart from the wrap bit
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr_s.ready = !full;
    assign wr_fire    = wr_s.valid && wr_s.ready;
    assign lost       = DROP_ON_FULL && wr_s.valid && full;  // Byte dropped on the floor
    assign end_frame  = wr_s.last && (wr_fire || lost);      // Frame boundary seen
    assign bad        = wr_s.err || ovf || lost;             // Frame must be rolled back

    always_ff @(posedge clk_125) begin
        if (wr_fire) begin
            mem[wr_ptr[AW-1:0]] <= {wr_s.last, wr_s.data};
        end
    end

    // Write pointer with commit and rollback
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            wr_ptr      <= '0;
            commit_ptr  <= '0;
            commit_pend <= 1'b0;
            ovf         <= 1'b0;
        end else begin
            if (commit_pend) begin
                commit_ptr <= wr_ptr;  // Frame end becomes visible to the reader
            end
            commit_pend <= end_frame && !bad;
            if (end_frame) begin
                ovf <= 1'b0;
                if (bad) begin
                    // A pending commit means this frame began at wr_ptr
                    wr_ptr <= commit_pend ? wr_ptr : commit_ptr;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end else begin
                if (lost) begin
                    ovf <= 1'b1;  // Remember until the frame ends
                end
                if (wr_fire) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Only committed bytes are fetched, so the reader never sees a partial frame
    assign avail = (rd_ptr != commit_ptr);
    assign load  = avail && (!rd_s.valid || rd_s.ready);

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            rd_ptr     <= '0;
            rd_s.valid <= 1'b0;
        end else begin
            if (load) begin
                rd_ptr     <= rd_ptr + 1'b1;
                rd_s.valid <= 1'b1;
            end else if (rd_s.ready) begin
                rd_s.valid <= 1'b0;  // Output register drained
            end
        end
    end

    always_ff @(posedge clk_125) begin
        if (load) begin
            {rd_s.last, rd_s.data} <= mem[rd_ptr[AW-1:0]];
        end
    end

    assign rd_s.err = 1'b0;  // Bad frames never leave the buffer

endmodule

`default_nettype wire

// ==== byte_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "eth_mac_fifo_defines.svh"

interface byte_stream_if;

    logic [`DATA_WIDTH-1:0] data;   // Payload byte
    logic                   valid;  // Byte present
    logic                   last;   // Final byte of a frame
    logic                   err;    // With last, drop the frame
    logic                   ready;  // Sink can take a byte

    modport source (
        output data,
        output valid,
        output last,
        output err,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  err,
        output ready
    );

endinterface

`default_nettype wire

// ==== eth_mac_fifo_pkg.sv ====
`default_nettype none
`include "eth_mac_fifo_defines.svh"

package eth_mac_fifo_pkg;

    localparam logic [`DATA_WIDTH-1:0] PREAMBLE_BYTE = 8'h55;  // Repeated ahead of the SFD
    localparam logic [`DATA_WIDTH-1:0] SFD_BYTE      = 8'hD5;  // Start of frame delimiter
    localparam int                     PREAMBLE_LEN  = 7;      // Preamble bytes before SFD
    localparam int                     FCS_BYTES     = 4;      // CRC-32 trailer length

    localparam logic [31:0] CRC_POLY    = 32'hEDB88320;        // Reflected 802.3 polynomial
    localparam logic [31:0] CRC_INIT    = 32'hFFFFFFFF;        // Preset to all ones
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;        // Register after data plus FCS

    // One byte of the bit-serial reflected CRC, LSB of the byte first
    function automatic logic [31:0] crc32_step(
        input logic [31:0]            crc,
        input logic [`DATA_WIDTH-1:0] data
    );
        logic [31:0] c;

        c = crc ^ {{(32 - `DATA_WIDTH){1'b0}}, data};  // Fold byte into low bits
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);  // Shift out one bit
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// ==== eth_mac_fifo_defines.svh ====
`ifndef ETH_MAC_FIFO_DEFINES_SVH
`define ETH_MAC_FIFO_DEFINES_SVH

// Byte lane width, shared by host streams and GMII
`define DATA_WIDTH 8

// Transmit buffer depth in bytes
// Holds one maximum frame so a whole frame can be gated
`define TX_FIFO_DEPTH 2048

// Receive buffer depth in bytes, small so overflow is reachable
`define RX_FIFO_DEPTH 256

// Bytes ahead of the FCS after padding
`define MIN_PAYLOAD 60

// Idle cycles after each transmitted frame
`define IFG_CYCLES 12

`endif
